// ==== verilog/axi_wr_mux_pkg.sv ====
/*
 * Shared definitions of the AXI-style write-path multiplexer
 *  - Port index, ID, address and data widths
 *  - Vector types for port IDs, downstream IDs, port index, address, data
 *  - Response code enum and arbiter state enum
 */
package axi_wr_mux_pkg;

  // Widths ---------------------------
  localparam int unsigned PortIdxWidth = 2;  // Index prepended to the ID, up to 4 ports
  localparam int unsigned SlvIdWidth   = 4;  // ID width on the requesting ports
  localparam int unsigned MstIdWidth   = SlvIdWidth + PortIdxWidth;
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;

  // Vector types ---------------------
  typedef logic [SlvIdWidth-1:0]   slv_id_t;    // Port side ID
  typedef logic [PortIdxWidth-1:0] port_idx_t;  // Requesting port number
  typedef logic [MstIdWidth-1:0]   mst_id_t;    // Port index above port ID
  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;      // One W beat

  // Write response code, AXI encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // AW arbiter states
  typedef enum logic {
    IDLE   = 1'b0,  // Free to pick a new port
    LOCKED = 1'b1   // Grant held until the AW is taken
  } arb_state_e;

endpackage

// ==== verilog/aw_rr_arbiter.sv ====
/*
 * Round-robin arbiter for the AW channel
 *  - Picks the first requesting port at or after the priority pointer
 *  - Locks the grant until the selected AW is accepted
 *  - Prepends the granted port index to the AW ID
 */
`timescale 1ns/1ps

module aw_rr_arbiter #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  // Requesting ports
  input  logic              [NumPorts-1:0]        req_valid_i,
  input  axi_wr_mux_pkg::slv_id_t [NumPorts-1:0]  req_id_i,
  input  axi_wr_mux_pkg::addr_t   [NumPorts-1:0]  req_addr_i,
  output logic              [NumPorts-1:0]        req_ready_o,
  // Arbitrated AW towards issue control
  output logic                                    arb_valid_o,
  output axi_wr_mux_pkg::mst_id_t                 arb_id_o,
  output axi_wr_mux_pkg::addr_t                   arb_addr_o,
  input  logic                                    arb_ready_i
);

  import axi_wr_mux_pkg::*;

  arb_state_e state_q, state_d;
  port_idx_t  rr_q, rr_d;               // Highest priority port
  port_idx_t  lock_idx_q, lock_idx_d;   // Port held while locked
  port_idx_t  sel_idx;                  // Round-robin pick this cycle
  port_idx_t  gnt_idx;                  // Port actually granted
  port_idx_t  nxt_idx;                  // Port after the granted one
  logic       any_req;

  // Search ---------------------------
  // Walk the ports starting at the pointer, wrapping at NumPorts
  always_comb begin : find_req
    int unsigned idx;
    idx     = 0;
    sel_idx = rr_q;
    any_req = 1'b0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      idx = (32'(rr_q) + i) % NumPorts;
      if (!any_req && req_valid_i[idx]) begin
        sel_idx = port_idx_t'(idx);
        any_req = 1'b1;
      end
    end
  end

  assign gnt_idx = (state_q == LOCKED) ? lock_idx_q : sel_idx;
  assign nxt_idx = (gnt_idx == port_idx_t'(NumPorts - 1)) ? '0 : gnt_idx + 1'b1;

  // Granted AW, with the index placed above the port ID
  assign arb_valid_o = req_valid_i[gnt_idx];       // Low when nothing requests
  assign arb_id_o    = {gnt_idx, req_id_i[gnt_idx]};
  assign arb_addr_o  = req_addr_i[gnt_idx];

  // Ready goes back to the granted port only
  always_comb begin
    req_ready_o          = '0;
    req_ready_o[gnt_idx] = arb_valid_o & arb_ready_i;
  end

  // Lock and priority update ---------
  always_comb begin
    state_d    = state_q;
    rr_d       = rr_q;
    lock_idx_d = lock_idx_q;
    unique case (state_q)
      IDLE: begin
        if (arb_valid_o) begin
          if (arb_ready_i) begin
            rr_d = nxt_idx;          // Taken at once, move priority on
          end else begin
            state_d    = LOCKED;     // Hold this port until accepted
            lock_idx_d = gnt_idx;
          end
        end
      end
      LOCKED: begin
        if (arb_valid_o && arb_ready_i) begin
          state_d = IDLE;
          rr_d    = nxt_idx;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= IDLE;
      rr_q       <= '0;
      lock_idx_q <= '0;
    end else begin
      state_q    <= state_d;
      rr_q       <= rr_d;
      lock_idx_q <= lock_idx_d;
    end
  end

endmodule

// ==== verilog/aw_issue_ctrl.sv ====
/*
 * AW issue control
 *  - Presents the arbitrated AW downstream while the order FIFO has room
 *  - Pushes the granted port index once per AW
 *  - Lock register keeps a stalled AW valid without a second push
 */
`timescale 1ns/1ps

module aw_issue_ctrl (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  // From the arbiter
  input  logic                        arb_valid_i,
  input  axi_wr_mux_pkg::mst_id_t     arb_id_i,
  input  axi_wr_mux_pkg::addr_t       arb_addr_i,
  output logic                        arb_ready_o,
  // Order FIFO
  input  logic                        fifo_full_i,
  output logic                        fifo_push_o,
  output axi_wr_mux_pkg::port_idx_t   push_idx_o,
  // Downstream AW
  output logic                        mst_aw_valid_o,
  output axi_wr_mux_pkg::mst_id_t     mst_aw_id_o,
  output axi_wr_mux_pkg::addr_t       mst_aw_addr_o,
  input  logic                        mst_aw_ready_i
);

  import axi_wr_mux_pkg::*;

  // Set when an AW was pushed but not yet taken downstream
  logic lock_q, lock_d;

  // Payload comes straight from the arbiter, which holds it while locked
  assign mst_aw_id_o   = arb_id_i;
  assign mst_aw_addr_o = arb_addr_i;
  assign push_idx_o    = arb_id_i[SlvIdWidth +: PortIdxWidth];  // Upper ID bits

  // Handshake control ----------------
  always_comb begin
    lock_d         = lock_q;
    fifo_push_o    = 1'b0;
    mst_aw_valid_o = 1'b0;
    arb_ready_o    = 1'b0;
    if (lock_q) begin
      // Index already queued, only finish the AW transfer
      mst_aw_valid_o = 1'b1;
      if (mst_aw_ready_i) begin
        arb_ready_o = 1'b1;
        lock_d      = 1'b0;
      end
    end else if (arb_valid_i && !fifo_full_i) begin
      // New AW, queue its port for the W path
      mst_aw_valid_o = 1'b1;
      fifo_push_o    = 1'b1;
      if (mst_aw_ready_i) begin
        arb_ready_o = 1'b1;        // Same-cycle accept
      end else begin
        lock_d = 1'b1;             // Stalled downstream
      end
    end
    // Full FIFO and no lock: AW waits, valid stays low
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

endmodule

// ==== verilog/w_steer.sv ====
/*
 * W channel steering
 *  - Order FIFO of granted port indices, one entry per issued AW
 *  - Connects the head port's W handshake to the downstream W channel
 *  - Pops the head on the transfer of the last beat
 */
`timescale 1ns/1ps

module w_steer #(
  parameter int unsigned NumPorts  = 4,
  parameter int unsigned MaxWTrans = 8   // FIFO depth, power of two
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  // Push side, from AW issue control
  input  logic                                  fifo_push_i,
  input  axi_wr_mux_pkg::port_idx_t             push_idx_i,
  output logic                                  fifo_full_o,
  // Requesting W ports
  input  logic              [NumPorts-1:0]      slv_w_valid_i,
  input  axi_wr_mux_pkg::data_t [NumPorts-1:0]  slv_w_data_i,
  input  logic              [NumPorts-1:0]      slv_w_last_i,
  output logic              [NumPorts-1:0]      slv_w_ready_o,
  // Downstream W
  output logic                                  mst_w_valid_o,
  output axi_wr_mux_pkg::data_t                 mst_w_data_o,
  output logic                                  mst_w_last_o,
  input  logic                                  mst_w_ready_i
);

  import axi_wr_mux_pkg::*;

  localparam int unsigned PtrWidth = $clog2(MaxWTrans);
  localparam int unsigned CntWidth = PtrWidth + 1;   // Holds 0..MaxWTrans

  port_idx_t           idx_mem [MaxWTrans];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic                fifo_empty;
  logic                fifo_pop;
  port_idx_t           head_idx;

  assign fifo_empty  = (cnt_q == '0);
  assign fifo_full_o = (cnt_q == CntWidth'(MaxWTrans));
  assign head_idx    = idx_mem[rd_ptr_q];

  // W multiplexer --------------------
  assign mst_w_data_o = slv_w_data_i[head_idx];
  assign mst_w_last_o = slv_w_last_i[head_idx];

  always_comb begin
    mst_w_valid_o = 1'b0;
    slv_w_ready_o = '0;           // Ports not at the head are stalled
    fifo_pop      = 1'b0;
    if (!fifo_empty) begin
      mst_w_valid_o           = slv_w_valid_i[head_idx];
      slv_w_ready_o[head_idx] = mst_w_ready_i;
      // Burst done, move to the next AW's port
      fifo_pop = slv_w_valid_i[head_idx] & mst_w_ready_i & slv_w_last_i[head_idx];
    end
  end

  // Order FIFO -----------------------
  always_ff @(posedge clk_i) begin
    if (fifo_push_i) begin
      idx_mem[wr_ptr_q] <= push_idx_i;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (fifo_push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (fifo_pop)    rd_ptr_q <= rd_ptr_q + 1'b1;
      unique case ({fifo_push_i, fifo_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;    // Both or neither
      endcase
    end
  end

endmodule

// ==== verilog/b_route.sv ====
/*
 * B response routing
 *  - Decodes the port index from the upper downstream ID bits
 *  - Raises only that port's valid and returns its ready
 *  - Strips the index, broadcasts port ID and response to all ports
 */
`timescale 1ns/1ps

module b_route #(
  parameter int unsigned NumPorts = 4
) (
  // Downstream B
  input  logic                                    mst_b_valid_i,
  input  axi_wr_mux_pkg::mst_id_t                 mst_b_id_i,
  input  axi_wr_mux_pkg::resp_e                   mst_b_resp_i,
  output logic                                    mst_b_ready_o,
  // Requesting B ports
  output logic              [NumPorts-1:0]        slv_b_valid_o,
  output axi_wr_mux_pkg::slv_id_t [NumPorts-1:0]  slv_b_id_o,
  output axi_wr_mux_pkg::resp_e   [NumPorts-1:0]  slv_b_resp_o,
  input  logic              [NumPorts-1:0]        slv_b_ready_i
);

  import axi_wr_mux_pkg::*;

  port_idx_t dst_idx;   // Port named by the ID prefix
  slv_id_t   port_id;   // ID as the port issued it

  assign dst_idx = mst_b_id_i[SlvIdWidth +: PortIdxWidth];
  assign port_id = mst_b_id_i[SlvIdWidth-1:0];

  // Decode -------------------------
  always_comb begin
    for (int unsigned i = 0; i < NumPorts; i++) begin
      slv_b_valid_o[i] = mst_b_valid_i && (dst_idx == port_idx_t'(i));
      slv_b_id_o[i]    = port_id;        // Same payload everywhere
      slv_b_resp_o[i]  = mst_b_resp_i;
    end
  end

  // Back-pressure from the addressed port only
  assign mst_b_ready_o = slv_b_ready_i[dst_idx];

endmodule

// ==== verilog/axi_wr_mux.sv ====
/*
 * Write-path multiplexer, NumPorts requesting ports onto one downstream port
 *  - Round-robin AW arbiter with port index prepended to the ID
 *  - AW issue control with lock register and outstanding limit
 *  - W steering in AW order through the order FIFO
 *  - B routing by ID prefix
 */
`timescale 1ns/1ps

module axi_wr_mux #(
  parameter int unsigned NumPorts  = 4,   // 2 to 4
  parameter int unsigned MaxWTrans = 8    // Outstanding W bursts, power of two
) (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  // Requesting ports, AW
  input  logic              [NumPorts-1:0]        slv_aw_valid_i,
  input  axi_wr_mux_pkg::slv_id_t [NumPorts-1:0]  slv_aw_id_i,
  input  axi_wr_mux_pkg::addr_t   [NumPorts-1:0]  slv_aw_addr_i,
  output logic              [NumPorts-1:0]        slv_aw_ready_o,
  // Requesting ports, W
  input  logic              [NumPorts-1:0]        slv_w_valid_i,
  input  axi_wr_mux_pkg::data_t   [NumPorts-1:0]  slv_w_data_i,
  input  logic              [NumPorts-1:0]        slv_w_last_i,
  output logic              [NumPorts-1:0]        slv_w_ready_o,
  // Requesting ports, B
  output logic              [NumPorts-1:0]        slv_b_valid_o,
  output axi_wr_mux_pkg::slv_id_t [NumPorts-1:0]  slv_b_id_o,
  output axi_wr_mux_pkg::resp_e   [NumPorts-1:0]  slv_b_resp_o,
  input  logic              [NumPorts-1:0]        slv_b_ready_i,
  // Downstream AW
  output logic                                    mst_aw_valid_o,
  output axi_wr_mux_pkg::mst_id_t                 mst_aw_id_o,
  output axi_wr_mux_pkg::addr_t                   mst_aw_addr_o,
  input  logic                                    mst_aw_ready_i,
  // Downstream W
  output logic                                    mst_w_valid_o,
  output axi_wr_mux_pkg::data_t                   mst_w_data_o,
  output logic                                    mst_w_last_o,
  input  logic                                    mst_w_ready_i,
  // Downstream B
  input  logic                                    mst_b_valid_i,
  input  axi_wr_mux_pkg::mst_id_t                 mst_b_id_i,
  input  axi_wr_mux_pkg::resp_e                   mst_b_resp_i,
  output logic                                    mst_b_ready_o
);

  import axi_wr_mux_pkg::*;

  // Arbiter to issue control
  logic      arb_valid, arb_ready;
  mst_id_t   arb_id;                // Already carries the port index
  addr_t     arb_addr;
  // Issue control to order FIFO
  logic      fifo_push, fifo_full;
  port_idx_t push_idx;

  // AW channel -----------------------
  aw_rr_arbiter #(
    .NumPorts    ( NumPorts       )
  ) i_aw_rr_arbiter (
    .clk_i       ( clk_i          ),
    .arst_n_i    ( arst_n_i       ),
    .req_valid_i ( slv_aw_valid_i ),
    .req_id_i    ( slv_aw_id_i    ),
    .req_addr_i  ( slv_aw_addr_i  ),
    .req_ready_o ( slv_aw_ready_o ),
    .arb_valid_o ( arb_valid      ),
    .arb_id_o    ( arb_id         ),
    .arb_addr_o  ( arb_addr       ),
    .arb_ready_i ( arb_ready      )
  );

  aw_issue_ctrl i_aw_issue_ctrl (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .arb_valid_i    ( arb_valid      ),
    .arb_id_i       ( arb_id         ),
    .arb_addr_i     ( arb_addr       ),
    .arb_ready_o    ( arb_ready      ),
    .fifo_full_i    ( fifo_full      ),  // Outstanding limit reached
    .fifo_push_o    ( fifo_push      ),
    .push_idx_o     ( push_idx       ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_id_o    ( mst_aw_id_o    ),
    .mst_aw_addr_o  ( mst_aw_addr_o  ),
    .mst_aw_ready_i ( mst_aw_ready_i )
  );

  // W channel ------------------------
  w_steer #(
    .NumPorts      ( NumPorts      ),
    .MaxWTrans     ( MaxWTrans     )
  ) i_w_steer (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .fifo_push_i   ( fifo_push     ),
    .push_idx_i    ( push_idx      ),
    .fifo_full_o   ( fifo_full     ),
    .slv_w_valid_i ( slv_w_valid_i ),
    .slv_w_data_i  ( slv_w_data_i  ),
    .slv_w_last_i  ( slv_w_last_i  ),
    .slv_w_ready_o ( slv_w_ready_o ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_data_o  ( mst_w_data_o  ),
    .mst_w_last_o  ( mst_w_last_o  ),
    .mst_w_ready_i ( mst_w_ready_i )
  );

  // B channel ------------------------
  b_route #(
    .NumPorts      ( NumPorts      )
  ) i_b_route (
    .mst_b_valid_i ( mst_b_valid_i ),
    .mst_b_id_i    ( mst_b_id_i    ),
    .mst_b_resp_i  ( mst_b_resp_i  ),
    .mst_b_ready_o ( mst_b_ready_o ),
    .slv_b_valid_o ( slv_b_valid_o ),
    .slv_b_id_o    ( slv_b_id_o    ),
    .slv_b_resp_o  ( slv_b_resp_o  ),
    .slv_b_ready_i ( slv_b_ready_i )
  );

endmodule

// ==== tb/tb_axi_wr_mux.sv ====
/*
 * Testbench of the write-path multiplexer
 *  - Table of write bursts, applied in batches that share the W stall flag
 *  - Downstream slave model with random AW, W and B handshakes
 *  - Checks ID prepend, W order, B routing, fairness, outstanding limit
 */
`timescale 1ns/1ps

module tb_axi_wr_mux;

  import axi_wr_mux_pkg::*;

  localparam int unsigned NumPorts  = 4;
  localparam int unsigned MaxWTrans = 8;
  localparam int unsigned NumRows   = 16;
  localparam int unsigned MaxCycles = 50 * NumRows + 100;

  // DUT signals ----------------------
  logic clk_i = 1'b0;
  logic arst_n_i;
  logic    [NumPorts-1:0] slv_aw_valid_i, slv_aw_ready_o;
  slv_id_t [NumPorts-1:0] slv_aw_id_i;
  addr_t   [NumPorts-1:0] slv_aw_addr_i;
  logic    [NumPorts-1:0] slv_w_valid_i, slv_w_last_i, slv_w_ready_o;
  data_t   [NumPorts-1:0] slv_w_data_i;
  logic    [NumPorts-1:0] slv_b_valid_o, slv_b_ready_i;
  slv_id_t [NumPorts-1:0] slv_b_id_o;
  resp_e   [NumPorts-1:0] slv_b_resp_o;
  logic    mst_aw_valid_o, mst_aw_ready_i;
  mst_id_t mst_aw_id_o, mst_b_id_i;
  addr_t   mst_aw_addr_o;
  logic    mst_w_valid_o, mst_w_last_o, mst_w_ready_i;
  data_t   mst_w_data_o;
  logic    mst_b_valid_i, mst_b_ready_o;
  resp_e   mst_b_resp_i;

  // Stimulus table with one write burst per row
  port_idx_t row_port  [NumRows];
  slv_id_t   row_id    [NumRows];
  addr_t     row_addr  [NumRows];
  int        row_beats [NumRows];
  data_t     row_data  [NumRows];   // Beat 0 data and base of the later beats
  logic      row_hold  [NumRows];   // Downstream W ready held low
  resp_e     row_resp  [NumRows];   // Expected B response
  int        num_rows = 0;

  // Scoreboard state
  int      aw_row [NumPorts];       // Row each port presents on AW
  int      aw_log [$];              // Port of every downstream AW in order
  int      aw_order [$];            // Rows whose W burst is not yet seen
  mst_id_t aw_id_q [$];             // Slave model record of AW IDs
  resp_e   aw_resp_q [$];           // Slave answer picked at AW time
  data_t   w_data_q [$];
  logic    w_last_q [$];
  int      w_beat = 0;
  int      b_row_q [$];
  mst_id_t b_id_q [$];
  resp_e   b_resp_q [$];
  int      b_done = 0;
  logic    w_hold = 1'b0;
  int      cycles = 0;

  axi_wr_mux #(
    .NumPorts  ( NumPorts  ),
    .MaxWTrans ( MaxWTrans )
  ) i_axi_wr_mux (.*);

  always #2 clk_i = ~clk_i;  // 4 ns period

  // Checks ---------------------------
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_id(input string name, input mst_id_t got, input mst_id_t exp);
    if (got !== exp) abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_slv_id(input string name, input slv_id_t got, input slv_id_t exp);
    if (got !== exp) abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input resp_e got, input resp_e exp);
    if (got !== exp) abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic add_row(input int port, input slv_id_t id, input addr_t addr, input int beats,
                         input data_t data, input logic hold, input resp_e resp);
    row_port[num_rows]  = port_idx_t'(port);
    row_id[num_rows]    = id;
    row_addr[num_rows]  = addr;
    row_beats[num_rows] = beats;
    row_data[num_rows]  = data;
    row_hold[num_rows]  = hold;
    row_resp[num_rows]  = resp;   // Address bit 31 set gives SLVERR
    num_rows++;
  endtask

  // Port drivers ---------------------
  // AW requests of one port for rows lo..hi in table order
  task automatic send_aw(input int p, input int lo, input int hi);
    for (int r = lo; r <= hi; r++) begin
      if (row_port[r] == p) begin
        @(negedge clk_i);
        aw_row[p]         = r;
        slv_aw_valid_i[p] = 1'b1;
        slv_aw_id_i[p]    = row_id[r];
        slv_aw_addr_i[p]  = row_addr[r];
        do @(posedge clk_i); while (!slv_aw_ready_o[p]);
      end
    end
    @(negedge clk_i);
    slv_aw_valid_i[p] = 1'b0;
  endtask

  // W bursts of one port in the order of its AWs
  task automatic send_w(input int p, input int lo, input int hi);
    for (int r = lo; r <= hi; r++) begin
      if (row_port[r] == p) begin
        for (int b = 0; b < row_beats[r]; b++) begin
          @(negedge clk_i);
          slv_w_valid_i[p] = 1'b1;
          slv_w_data_i[p]  = row_data[r] + data_t'(b);
          slv_w_last_i[p]  = (b == row_beats[r] - 1);
          do @(posedge clk_i); while (!slv_w_ready_o[p]);
        end
      end
    end
    @(negedge clk_i);
    slv_w_valid_i[p] = 1'b0;
  endtask

  // With W stalled, the AW count must stop at the FIFO depth
  task automatic hold_check(input int lo, input int aw_start);
    if (row_hold[lo]) begin
      while (aw_log.size() - aw_start < int'(MaxWTrans)) @(negedge clk_i);
      repeat (20) @(negedge clk_i);
      if (aw_log.size() - aw_start != int'(MaxWTrans)) begin
        abort_run("More AWs were accepted than the outstanding limit while W was stalled");
      end
      w_hold <= 1'b0;   // Release W so the rest can drain
    end
  endtask

  // Slave model ----------------------
  initial begin : slave_model
    slv_b_ready_i  = '0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = OKAY;
    void'($urandom(32'hd37571f4));
    forever begin
      @(negedge clk_i);
      mst_aw_ready_i = ($urandom % 4) != 0;
      mst_w_ready_i  = !w_hold && (($urandom % 4) != 0);
      slv_b_ready_i  = NumPorts'($urandom);       // Port side B back-pressure
      mst_b_valid_i  = (b_id_q.size() > 0);
      if (b_id_q.size() > 0) begin
        mst_b_id_i   = b_id_q[0];                 // Echo the recorded AW ID
        mst_b_resp_i = b_resp_q[0];
      end
    end
  end

  // Monitor that owns every scoreboard queue
  always @(posedge clk_i) begin : monitor
    int p;
    int r;
    if (arst_n_i) begin
      // B routing to the port named in the ID
      if (mst_b_valid_i) begin
        r = b_row_q[0];
        check_flag("mst_b_ready_o", mst_b_ready_o, slv_b_ready_i[row_port[r]]);
        for (int i = 0; i < NumPorts; i++) begin
          check_flag($sformatf("slv_b_valid_o[%0d]", i), slv_b_valid_o[i], i == row_port[r]);
        end
        check_slv_id("slv_b_id_o", slv_b_id_o[row_port[r]], row_id[r]);
        check_resp("slv_b_resp_o", slv_b_resp_o[row_port[r]], row_resp[r]);
        if (mst_b_ready_o) begin
          void'(b_row_q.pop_front());
          void'(b_id_q.pop_front());
          void'(b_resp_q.pop_front());
          b_done++;
        end
      end
      // Find the port that handed its AW request over
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        p = -1;
        for (int i = 0; i < NumPorts; i++) begin
          if (slv_aw_valid_i[i] && slv_aw_ready_o[i]) p = i;
        end
        if (p < 0) begin
          abort_run("A downstream AW was accepted without any port AW handshake");
        end else begin
          r = aw_row[p];
          check_id("mst_aw_id_o", mst_aw_id_o, {port_idx_t'(p), row_id[r]});
          check_addr("mst_aw_addr_o", mst_aw_addr_o, row_addr[r]);
          aw_log.push_back(p);
          aw_order.push_back(r);
          aw_id_q.push_back(mst_aw_id_o);
          aw_resp_q.push_back(mst_aw_addr_o[31] ? SLVERR : OKAY);
        end
      end
      // W beats may run ahead of a stalled AW
      if (mst_w_valid_o && mst_w_ready_i) begin
        w_data_q.push_back(mst_w_data_o);
        w_last_q.push_back(mst_w_last_o);
      end
      while (w_data_q.size() > 0 && aw_order.size() > 0) begin
        r = aw_order[0];
        check_data("mst_w_data_o", w_data_q[0], row_data[r] + data_t'(w_beat));
        check_flag("mst_w_last_o", w_last_q[0], w_beat == row_beats[r] - 1);
        void'(w_data_q.pop_front());
        void'(w_last_q.pop_front());
        if (w_beat == row_beats[r] - 1) begin
          b_row_q.push_back(aw_order.pop_front());   // Burst complete so its B may go
          b_id_q.push_back(aw_id_q.pop_front());
          b_resp_q.push_back(aw_resp_q.pop_front());
          w_beat = 0;
        end else begin
          w_beat++;
        end
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= MaxCycles) abort_run("Timeout, the run did not finish in time");
  end

  // Main sequence --------------------
  initial begin : main
    int lo;
    int hi;
    int aw_start;
    int b_start;
    logic [NumPorts-1:0] seen;
    // Batch 1 with W flowing
    add_row(0, 4'h3, 32'h0000_1000, 2, 32'h1000_0000, 1'b0, OKAY);
    add_row(1, 4'h5, 32'h8000_2000, 1, 32'h2000_0000, 1'b0, SLVERR);
    add_row(2, 4'hA, 32'h0000_3000, 4, 32'h3000_0000, 1'b0, OKAY);
    add_row(3, 4'hF, 32'h8000_4000, 3, 32'h4000_0000, 1'b0, SLVERR);
    // Batch 2 with W stalled until the limit is reached
    add_row(0, 4'h1, 32'h0000_1100, 1, 32'h1100_0000, 1'b1, OKAY);
    add_row(1, 4'h2, 32'h0000_2100, 2, 32'h2100_0000, 1'b1, OKAY);
    add_row(2, 4'h3, 32'h8000_3100, 1, 32'h3100_0000, 1'b1, SLVERR);
    add_row(3, 4'h4, 32'h0000_4100, 2, 32'h4100_0000, 1'b1, OKAY);
    add_row(0, 4'h5, 32'h8000_1200, 3, 32'h1200_0000, 1'b1, SLVERR);
    add_row(1, 4'h6, 32'h0000_2200, 1, 32'h2200_0000, 1'b1, OKAY);
    add_row(2, 4'h7, 32'h0000_3200, 2, 32'h3200_0000, 1'b1, OKAY);
    add_row(3, 4'h8, 32'h8000_4200, 1, 32'h4200_0000, 1'b1, SLVERR);
    add_row(0, 4'h9, 32'h0000_1300, 2, 32'h1300_0000, 1'b1, OKAY);
    add_row(1, 4'hA, 32'h8000_2300, 4, 32'h2300_0000, 1'b1, SLVERR);
    add_row(2, 4'hB, 32'h0000_3300, 1, 32'h3300_0000, 1'b1, OKAY);
    add_row(3, 4'hC, 32'h0000_4300, 3, 32'h4300_0000, 1'b1, OKAY);
    arst_n_i       = 1'b0;
    slv_aw_valid_i = '0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_w_valid_i  = '0;
    slv_w_data_i   = '0;
    slv_w_last_i   = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    check_flag("mst_aw_valid_o", mst_aw_valid_o, 1'b0);   // Idle after reset
    check_flag("mst_w_valid_o", mst_w_valid_o, 1'b0);
    lo = 0;
    while (lo < num_rows) begin
      hi = lo;
      while (hi + 1 < num_rows && row_hold[hi + 1] == row_hold[lo]) hi++;
      aw_start = aw_log.size();
      b_start  = b_done;
      w_hold  <= row_hold[lo];
      fork
        send_aw(0, lo, hi);
        send_aw(1, lo, hi);
        send_aw(2, lo, hi);
        send_aw(3, lo, hi);
        send_w(0, lo, hi);
        send_w(1, lo, hi);
        send_w(2, lo, hi);
        send_w(3, lo, hi);
        hold_check(lo, aw_start);
      join
      while (b_done - b_start < hi - lo + 1) @(negedge clk_i);
      // Four ports requested together so four different ports win first
      seen = '0;
      for (int i = 0; i < NumPorts; i++) begin
        seen[aw_log[aw_start + i]] = 1'b1;
      end
      if (seen != '1) abort_run("The first four AWs of a batch did not come from four ports");
      lo = hi + 1;
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== axi_wr_mux.f ====
verilog/axi_wr_mux_pkg.sv
verilog/aw_rr_arbiter.sv
verilog/aw_issue_ctrl.sv
verilog/w_steer.sv
verilog/b_route.sv
verilog/axi_wr_mux.sv
tb/tb_axi_wr_mux.sv

// ==== Bender.yml ====
package:
  name: axi_wr_mux

sources:
  - verilog/axi_wr_mux_pkg.sv
  - verilog/aw_rr_arbiter.sv
  - verilog/aw_issue_ctrl.sv
  - verilog/w_steer.sv
  - verilog/b_route.sv
  - verilog/axi_wr_mux.sv
  - target: test
    files:
      - tb/tb_axi_wr_mux.sv
